// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= fetch_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== common/fetch_macros.svh ====
`ifndef FETCH_MACROS_SVH
`define FETCH_MACROS_SVH

// ********************
// cache geometry
// ********************
`define FETCH_LINE_WORDS 4              // 32-bit words per line
`define FETCH_SETS       16             // direct mapped, one line per set

// ********************
// fetch control
// ********************
`define FETCH_CREDITS    2              // slots in the decode buffer
`define FETCH_RESET_PC   32'h3000_0000

// bursts are only legal inside the SDRAM window
`define FETCH_SDRAM_BASE 32'hA000_0000
`define FETCH_SDRAM_END  32'hBFFF_FFFF

`endif

// ==== common/fetch_pkg.sv ====
`include "fetch_macros.svh"

package fetch_pkg;

    // ********************
    // cache side
    // ********************
    typedef logic [`FETCH_LINE_WORDS*32-1:0] line_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;                 // zero when fault is set
        logic        fault;
    } fetch_pkt_t;

    typedef struct packed {
        logic [31:0] addr;                 // line aligned
    } refill_req_t;

    typedef struct packed {
        line_t      line;
        logic       fault;
        logic [1:0] fault_idx;             // first word that came back with an error
    } refill_rsp_t;

    // ********************
    // AXI4 read channels
    // ********************
    typedef struct packed {
        logic [31:0] araddr;
        logic [3:0]  arid;
        logic [7:0]  arlen;
        logic [2:0]  arsize;
        logic [1:0]  arburst;
    } axi_ar_t;

    typedef struct packed {
        logic [31:0] rdata;
        logic [1:0]  rresp;
        logic        rlast;
        logic [3:0]  rid;
    } axi_r_t;

    localparam logic [1:0] AXI_BURST_FIXED = 2'b00;
    localparam logic [1:0] AXI_BURST_INCR  = 2'b01;
    localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;

endpackage

// ==== fetch_top.f ====
+incdir+common
common/fetch_pkg.sv
hw/icache/icache_array.sv
hw/icache/icache_refill.sv
hw/ifu/ifu_ctrl.sv
hw/fetch_top.sv
tests/axi_rom_model.sv
tests/fetch_tb.sv

// ==== hw/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top (
    input  logic                  clk,
    input  logic                  rst,
    output logic                  ar_valid,
    input  logic                  ar_ready,
    output fetch_pkg::axi_ar_t    ar,
    input  logic                  r_valid,
    output logic                  r_ready,
    input  fetch_pkg::axi_r_t     r,
    output logic                  pkt_valid,
    output fetch_pkg::fetch_pkt_t pkt,
    input  logic                  credit_return,
    input  logic                  redirect_valid,
    input  logic [31:0]           redirect_pc
);
    logic [31:0]            lookup_addr;
    logic                   hit;
    logic [31:0]            hit_inst;
    logic                   refill_req_valid;
    fetch_pkg::refill_req_t refill_req;
    logic                   refill_rsp_valid;
    fetch_pkg::refill_rsp_t refill_rsp;

    ifu_ctrl u_ifu_ctrl (
        .clk              (clk),
        .rst              (rst),
        .lookup_addr      (lookup_addr),
        .hit              (hit),
        .hit_inst         (hit_inst),
        .refill_req_valid (refill_req_valid),
        .refill_req       (refill_req),
        .refill_rsp_valid (refill_rsp_valid),
        .refill_rsp       (refill_rsp),
        .redirect_valid   (redirect_valid),
        .redirect_pc      (redirect_pc),
        .credit_return    (credit_return),
        .pkt_valid        (pkt_valid),
        .pkt              (pkt)
    );

    // the line is written at the index and tag of the held request
    icache_array u_icache_array (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .hit_inst    (hit_inst),
        .fill_valid  (refill_rsp_valid),
        .fill_addr   (refill_req.addr),
        .fill_line   (refill_rsp.line),
        .fill_fault  (refill_rsp.fault)
    );

    icache_refill u_icache_refill (
        .clk       (clk),
        .rst       (rst),
        .req_valid (refill_req_valid),
        .req       (refill_req),
        .rsp_valid (refill_rsp_valid),
        .rsp       (refill_rsp),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar        (ar),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r         (r)
    );

endmodule

// ==== hw/icache/icache_array.sv ====
`timescale 1ns/10ps
`include "fetch_macros.svh"

module icache_array (
    input  logic             clk,
    input  logic             rst,
    input  logic [31:0]      lookup_addr,
    output logic             hit,
    output logic [31:0]      hit_inst,
    input  logic             fill_valid,
    input  logic [31:0]      fill_addr,
    input  fetch_pkg::line_t fill_line,
    input  logic             fill_fault
);
    localparam int WORD_W = $clog2(`FETCH_LINE_WORDS);
    localparam int OFF_W  = WORD_W + 2;
    localparam int IDX_W  = $clog2(`FETCH_SETS);
    localparam int TAG_W  = 32 - IDX_W - OFF_W;

    logic [TAG_W-1:0]  tags  [`FETCH_SETS];
    fetch_pkg::line_t  lines [`FETCH_SETS];
    logic [`FETCH_SETS-1:0] valid;

    logic [IDX_W-1:0]  lk_idx;
    logic [TAG_W-1:0]  lk_tag;
    logic [WORD_W-1:0] lk_word;
    logic [IDX_W-1:0]  fill_idx;
    logic [TAG_W-1:0]  fill_tag;
    logic              fill_we;
    fetch_pkg::line_t  lk_line;

    // ********************
    // lookup
    // ********************
    assign lk_idx  = lookup_addr[OFF_W +: IDX_W];
    assign lk_tag  = lookup_addr[31 -: TAG_W];
    assign lk_word = lookup_addr[OFF_W-1:2];
    assign lk_line = lines[lk_idx];

    assign hit      = valid[lk_idx] && (tags[lk_idx] == lk_tag);
    assign hit_inst = lk_line[32*lk_word +: 32];

    // ********************
    // line fill
    // ********************
    assign fill_idx = fill_addr[OFF_W +: IDX_W];
    assign fill_tag = fill_addr[31 -: TAG_W];
    assign fill_we  = fill_valid && !fill_fault;   // a faulted line never lands in the cache

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid <= '0;
        end else if (fill_we) begin
            valid[fill_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tags[fill_idx]  <= fill_tag;
            lines[fill_idx] <= fill_line;
        end
    end

endmodule

// ==== hw/icache/icache_refill.sv ====
`timescale 1ns/10ps
`include "fetch_macros.svh"

module icache_refill (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req_valid,
    input  fetch_pkg::refill_req_t req,
    output logic                   rsp_valid,
    output fetch_pkg::refill_rsp_t rsp,
    output logic                   ar_valid,
    input  logic                   ar_ready,
    output fetch_pkg::axi_ar_t     ar,
    input  logic                   r_valid,
    output logic                   r_ready,
    input  fetch_pkg::axi_r_t      r
);
    localparam int WORD_W = $clog2(`FETCH_LINE_WORDS);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_AR   = 2'd1;
    localparam logic [1:0] S_R    = 2'd2;

    logic [1:0]        state;
    logic [WORD_W-1:0] beat;
    logic              burst_mode;
    logic              in_sdram;
    logic              start;
    logic              r_fire;
    logic              bad_resp;
    logic              last_beat;

    assign in_sdram = (req.addr >= `FETCH_SDRAM_BASE) && (req.addr <= `FETCH_SDRAM_END);
    // the controller still holds its request while the response pulses
    assign start    = (state == S_IDLE) && req_valid && !rsp_valid;
    assign r_fire   = r_valid && r_ready;
    assign bad_resp = r.rresp != fetch_pkg::AXI_RESP_OKAY;

    // a burst always drains to rlast, single reads stop at the first error
    assign last_beat = burst_mode ? r.rlast : (bad_resp || beat == '1);

    // ********************
    // channel control
    // ********************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= S_IDLE;
            beat       <= '0;
            burst_mode <= 1'b0;
            ar_valid   <= 1'b0;
            r_ready    <= 1'b0;
            rsp_valid  <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        ar_valid   <= 1'b1;
                        beat       <= '0;
                        burst_mode <= in_sdram;
                        state      <= S_AR;
                    end
                end
                S_AR: begin
                    if (ar_ready) begin
                        ar_valid <= 1'b0;
                        r_ready  <= 1'b1;
                        state    <= S_R;
                    end
                end
                S_R: begin
                    if (r_valid) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            r_ready   <= 1'b0;
                            rsp_valid <= 1'b1;
                            state     <= S_IDLE;
                        end else if (!burst_mode) begin
                            r_ready  <= 1'b0;     // next single read
                            ar_valid <= 1'b1;
                            state    <= S_AR;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // ********************
    // address and line data
    // ********************
    always_ff @(posedge clk) begin
        if (start) begin
            ar.araddr     <= req.addr;
            ar.arid       <= 4'h0;
            ar.arsize     <= 3'd2;                   // word beats
            ar.arlen      <= in_sdram ? 8'(`FETCH_LINE_WORDS - 1) : 8'd0;
            ar.arburst    <= in_sdram ? fetch_pkg::AXI_BURST_INCR : fetch_pkg::AXI_BURST_FIXED;
            rsp.fault     <= 1'b0;
            rsp.fault_idx <= 2'd0;
        end
        if (r_fire) begin
            if (!rsp.fault) begin
                if (bad_resp) begin
                    rsp.fault     <= 1'b1;
                    rsp.fault_idx <= beat;
                end else begin
                    rsp.line[32*beat +: 32] <= r.rdata;
                end
            end
            if (!burst_mode && !last_beat) begin
                ar.araddr <= ar.araddr + 32'd4;
            end
        end
    end

endmodule

// ==== hw/ifu/ifu_ctrl.sv ====
`timescale 1ns/10ps
`include "fetch_macros.svh"

module ifu_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    output logic [31:0]            lookup_addr,
    input  logic                   hit,
    input  logic [31:0]            hit_inst,
    output logic                   refill_req_valid,
    output fetch_pkg::refill_req_t refill_req,
    input  logic                   refill_rsp_valid,
    input  fetch_pkg::refill_rsp_t refill_rsp,
    input  logic                   redirect_valid,
    input  logic [31:0]            redirect_pc,
    input  logic                   credit_return,
    output logic                   pkt_valid,
    output fetch_pkg::fetch_pkt_t  pkt
);
    localparam int CREDIT_W = $clog2(`FETCH_CREDITS + 1);
    localparam int WORD_W   = $clog2(`FETCH_LINE_WORDS);
    localparam int OFF_W    = WORD_W + 2;

    localparam logic [1:0] S_IDLE    = 2'd0;
    localparam logic [1:0] S_MISS    = 2'd1;
    localparam logic [1:0] S_DELIVER = 2'd2;   // line is back but no credit yet

    logic [1:0]          state;
    logic [31:0]         pc;
    logic [CREDIT_W-1:0] credits;
    logic                kill;                  // redirect arrived while the refill ran
    logic                has_credit;
    logic                send;
    logic [WORD_W-1:0]   word_sel;
    logic [31:0]         miss_inst;
    logic                miss_fault;
    logic [31:0]         hold_inst;
    logic                hold_fault;
    logic [31:0]         out_inst;
    logic                out_fault;

    assign lookup_addr = pc;
    assign has_credit  = credits != '0;
    assign word_sel    = pc[OFF_W-1:2];

    // words ahead of the failing beat are still good
    assign miss_fault = refill_rsp.fault && (word_sel >= refill_rsp.fault_idx);
    assign miss_inst  = miss_fault ? 32'h0 : refill_rsp.line[32*word_sel +: 32];

    always_comb begin
        send      = 1'b0;
        out_inst  = hit_inst;
        out_fault = 1'b0;
        case (state)
            S_IDLE: begin
                send = hit && has_credit && !redirect_valid;
            end
            S_MISS: begin
                send      = refill_rsp_valid && !kill && has_credit && !redirect_valid;
                out_inst  = miss_inst;
                out_fault = miss_fault;
            end
            S_DELIVER: begin
                send      = has_credit && !redirect_valid;
                out_inst  = hold_inst;
                out_fault = hold_fault;
            end
            default: send = 1'b0;
        endcase
    end

    // ********************
    // credit counter
    // ********************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            credits <= CREDIT_W'(`FETCH_CREDITS);
        end else begin
            credits <= credits + CREDIT_W'(credit_return) - CREDIT_W'(send);
        end
    end

    // ********************
    // pc and fetch FSM
    // ********************
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state            <= S_IDLE;
            pc               <= `FETCH_RESET_PC;
            kill             <= 1'b0;
            pkt_valid        <= 1'b0;
            refill_req_valid <= 1'b0;
        end else begin
            pkt_valid <= send;
            if (redirect_valid) begin
                pc <= redirect_pc;
            end else if (send) begin
                pc <= pc + 32'd4;
            end
            case (state)
                S_IDLE: begin
                    if (!redirect_valid && !hit) begin
                        refill_req_valid <= 1'b1;
                        kill             <= 1'b0;
                        state            <= S_MISS;
                    end
                end
                S_MISS: begin
                    if (redirect_valid) begin
                        kill <= 1'b1;
                    end
                    if (refill_rsp_valid) begin
                        refill_req_valid <= 1'b0;
                        if (kill || redirect_valid || has_credit) begin
                            state <= S_IDLE;        // sent now or dropped as stale
                        end else begin
                            state <= S_DELIVER;
                        end
                    end
                end
                S_DELIVER: begin
                    if (redirect_valid || has_credit) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && !hit) begin
            refill_req.addr <= {pc[31:OFF_W], {OFF_W{1'b0}}};
        end
        if (state == S_MISS && refill_rsp_valid) begin
            hold_inst  <= miss_inst;
            hold_fault <= miss_fault;
        end
        if (send) begin
            pkt.pc    <= pc;
            pkt.inst  <= out_inst;
            pkt.fault <= out_fault;
        end
    end

endmodule

// ==== tests/axi_rom_model.sv ====
`timescale 1ns/10ps

module axi_rom_model #(
    parameter logic [31:0] KEY    = 32'h1357_9BDF,
    parameter logic [31:0] ERR_LO = 32'h5000_0000,
    parameter logic [31:0] ERR_HI = 32'h5000_00FF
) (
    input  logic               clk,
    input  logic               rst,
    input  logic [3:0]         stall,          // low pair delays ar_ready, high pair r_valid
    input  logic               ar_valid,
    output logic               ar_ready,
    input  fetch_pkg::axi_ar_t ar,
    output logic               r_valid,
    input  logic               r_ready,
    output fetch_pkg::axi_r_t  r
);
    fetch_pkg::axi_ar_t ar_q;
    logic [31:0]        addr;
    logic [8:0]         beats_left;
    logic               incr;
    logic               ar_fire;
    logic               r_fire;
    logic               ar_seen;
    logic [1:0]         ar_wait;
    logic [1:0]         r_wait;

    initial begin
        ar_ready   = 1'b0;
        r_valid    = 1'b0;
        r          = '0;
        addr       = '0;
        beats_left = '0;
        incr       = 1'b0;
        ar_wait    = '0;
        r_wait     = '0;
        forever begin
            @(negedge clk);
            ar_fire = ar_valid && ar_ready;
            r_fire  = r_valid && r_ready;
            ar_seen = ar_valid;
            ar_q    = ar;
            @(posedge clk);
            #2;
            if (rst) begin
                ar_ready   = 1'b0;
                r_valid    = 1'b0;
                beats_left = '0;
                ar_wait    = stall[1:0];
                r_wait     = stall[3:2];
            end else begin
                // ********************
                // address channel
                // ********************
                if (ar_fire) begin
                    ar_ready   = 1'b0;
                    addr       = ar_q.araddr;
                    beats_left = 9'(ar_q.arlen) + 9'd1;
                    incr       = ar_q.arburst == fetch_pkg::AXI_BURST_INCR;
                    ar_wait    = stall[1:0];
                end else if (ar_seen && !ar_ready && beats_left == '0) begin
                    if (ar_wait == '0) begin
                        ar_ready = 1'b1;
                    end else begin
                        ar_wait = ar_wait - 2'd1;
                    end
                end
                // ********************
                // read data channel
                // ********************
                if (r_fire) begin
                    r_valid    = 1'b0;
                    beats_left = beats_left - 9'd1;
                    r_wait     = stall[3:2];
                    if (incr) begin
                        addr = addr + 32'd4;
                    end
                end
                if (beats_left != '0 && !r_valid) begin
                    if (r_wait == '0) begin
                        r_valid = 1'b1;
                        r.rdata = addr ^ KEY;
                        r.rresp = (addr >= ERR_LO && addr <= ERR_HI) ? 2'b10 : 2'b00;
                        r.rlast = beats_left == 9'd1;
                        r.rid   = 4'h0;
                    end else begin
                        r_wait = r_wait - 2'd1;
                    end
                end
            end
        end
    end

endmodule

// ==== tests/fetch_tb.sv ====
`timescale 1ns/10ps
`include "fetch_macros.svh"

module fetch_tb;
    localparam logic [31:0] ROM_KEY    = 32'h1357_9BDF;
    localparam logic [31:0] FAULT_LO   = 32'h5000_0000;
    localparam logic [31:0] FAULT_HI   = 32'h5000_00FF;
    localparam int          N_ROWS     = 7;
    localparam int          ROW_CYCLES = 400;
    localparam int          RST_CYCLES = 5;

    typedef struct packed {
        logic        redirect;
        logic [31:0] target;
        logic        late;                     // redirect again once the refill is on the bus
        logic [31:0] late_target;
        logic [7:0]  count;
        logic        throttle;
        logic        check_ar;
        logic [7:0]  ar_count;
        logic        burst;
    } row_t;

    logic                  clk;
    logic                  rst;
    logic                  ar_valid;
    logic                  ar_ready;
    fetch_pkg::axi_ar_t    ar;
    logic                  r_valid;
    logic                  r_ready;
    fetch_pkg::axi_r_t     r;
    logic                  pkt_valid;
    fetch_pkg::fetch_pkt_t pkt;
    logic                  credit_return;
    logic                  redirect_valid;
    logic [31:0]           redirect_pc;
    logic [3:0]            stall;

    row_t        rows [N_ROWS];
    row_t        cur;
    logic [31:0] lfsr;
    logic [31:0] exp_pc;
    logic [31:0] win_lo;
    logic [31:0] win_hi;
    int          outstanding;
    int          collected;
    int          ar_hits;

    fetch_top u_dut (
        .clk            (clk),
        .rst            (rst),
        .ar_valid       (ar_valid),
        .ar_ready       (ar_ready),
        .ar             (ar),
        .r_valid        (r_valid),
        .r_ready        (r_ready),
        .r              (r),
        .pkt_valid      (pkt_valid),
        .pkt            (pkt),
        .credit_return  (credit_return),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

    axi_rom_model #(.KEY(ROM_KEY), .ERR_LO(FAULT_LO), .ERR_HI(FAULT_HI)) u_rom (
        .clk      (clk),
        .rst      (rst),
        .stall    (stall),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic take_bit();
        logic fb;
        fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
        lfsr = {lfsr[30:0], fb};
        return fb;
    endfunction

    function automatic logic in_fault(input logic [31:0] a);
        return a >= FAULT_LO && a <= FAULT_HI;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string what);
        stop_run($sformatf("Mismatch at %0t ns: %s", $time, what));
    endtask

    task automatic open_window(input logic [31:0] lo, input logic [7:0] count);
        win_lo    = lo;
        win_hi    = lo + 32'(count) * 32'd4 - 32'd1;
        collected = 0;
        ar_hits   = 0;
    endtask

    task automatic redirect_to(input logic [31:0] target, input logic [7:0] count);
        redirect_valid = 1'b1;
        redirect_pc    = target;
        @(posedge clk);
        #2;
        redirect_valid = 1'b0;
        open_window(target, count);         // the in-flight old packet is already counted
    endtask

    task automatic check_cycle();
        logic        exp_fault;
        logic [31:0] exp_inst;
        if (pkt_valid) begin
            exp_fault = in_fault(exp_pc);
            exp_inst  = exp_fault ? 32'h0 : (exp_pc ^ ROM_KEY);
            assert (pkt.pc == exp_pc)
                else report_mismatch($sformatf("pc %h, expected %h", pkt.pc, exp_pc));
            assert (pkt.fault == exp_fault)
                else report_mismatch($sformatf("fault %b at pc %h", pkt.fault, exp_pc));
            assert (pkt.inst == exp_inst)
                else report_mismatch($sformatf("inst %h at pc %h, expected %h",
                                               pkt.inst, exp_pc, exp_inst));
            exp_pc      = exp_pc + 32'd4;
            outstanding = outstanding + 1;
            collected   = collected + 1;
            assert (outstanding <= `FETCH_CREDITS)
                else stop_run("decode received more packets than it has buffer slots");
        end
        if (credit_return) begin
            outstanding = outstanding - 1;
        end
        if (redirect_valid) begin
            exp_pc = redirect_pc;            // takes effect at the next edge
        end
        if (ar_valid && ar_ready && ar.araddr >= win_lo && ar.araddr <= win_hi) begin
            ar_hits = ar_hits + 1;
            if (cur.burst) begin
                assert (ar.arlen == 8'd3 && ar.arsize == 3'd2 &&
                        ar.arburst == fetch_pkg::AXI_BURST_INCR)
                    else report_mismatch($sformatf("arlen %0d arsize %0d arburst %0d at %h",
                                                   ar.arlen, ar.arsize, ar.arburst,
                                                   ar.araddr));
            end
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ********************
    // stimulus table
    // ********************
    initial begin
        rst            = 1'b1;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        //            redir target         late target         cnt    thr   chk   ars    burst
        rows[0] = '{1'b0, 32'h3000_0000, 1'b0, 32'h0,          8'd12, 1'b0, 1'b1, 8'd12, 1'b0};
        rows[1] = '{1'b1, 32'hA000_0000, 1'b0, 32'h0,          8'd12, 1'b0, 1'b1, 8'd3,  1'b1};
        rows[2] = '{1'b1, 32'hA000_0000, 1'b0, 32'h0,          8'd12, 1'b0, 1'b1, 8'd0,  1'b0};
        rows[3] = '{1'b1, 32'h5000_0010, 1'b0, 32'h0,          8'd4,  1'b0, 1'b0, 8'd0,  1'b0};
        rows[4] = '{1'b1, 32'hA000_0010, 1'b0, 32'h0,          8'd4,  1'b0, 1'b1, 8'd0,  1'b0};
        rows[5] = '{1'b1, 32'h3000_0100, 1'b0, 32'h0,          8'd16, 1'b1, 1'b0, 8'd0,  1'b0};
        rows[6] = '{1'b1, 32'h3000_0200, 1'b1, 32'hA000_0400, 8'd4,  1'b0, 1'b0, 8'd0,  1'b0};
        cur = rows[0];
        open_window(`FETCH_RESET_PC, rows[0].count);
        repeat (RST_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < N_ROWS; i++) begin
            cur = rows[i];
            if (cur.redirect) begin
                redirect_to(cur.target, cur.count);
            end
            if (cur.late) begin
                while (ar_hits == 0) begin
                    @(posedge clk);
                    #2;
                end
                redirect_to(cur.late_target, cur.count);
            end
            while (collected < int'(cur.count)) begin
                @(posedge clk);
                #2;
            end
            if (cur.check_ar) begin
                assert (ar_hits == int'(cur.ar_count))
                    else report_mismatch($sformatf("%0d AR handshakes in row %0d, expected %0d",
                                                   ar_hits, i, cur.ar_count));
            end
        end
        $display("test passed");
        $finish;
    end

    // credit return and model stalls, one LFSR bit per random choice
    initial begin
        credit_return = 1'b0;
        stall         = '0;
        lfsr          = 32'hff6;
        forever begin
            @(posedge clk);
            #2;
            for (int i = 0; i < 4; i++) begin
                stall[i] = take_bit();
            end
            credit_return = outstanding > 0;
            if (credit_return && cur.throttle) begin
                credit_return = take_bit();
            end
        end
    end

    initial begin
        exp_pc      = `FETCH_RESET_PC;
        outstanding = 0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                check_cycle();
            end
        end
    end

    initial begin
        repeat (RST_CYCLES + ROW_CYCLES * N_ROWS) @(posedge clk);
        stop_run("fetch stalled: the watchdog expired before all packets arrived");
    end

endmodule
